/* design/byte_stream_if.sv */
`timescale 1ns/1ps

interface byte_stream_if;
	logic valid;
	logic ready;
	logic [7:0] data;
	logic last;

	// Source holds valid, data and last until the byte is taken
	modport source (
		output valid, output data, output last,
		input ready
	);
	modport sink (
		input valid, input data, input last,
		output ready
	);
endinterface

/* design/host_reply_arbiter.sv */
`timescale 1ns/1ps

module host_reply_arbiter import mbus_frame_pkg::*; (
	input  logic clk,
	input  logic reset,
	byte_stream_if.sink rx_in,
	reply_if.sink reply,
	output logic host_out_valid,
	output logic [7:0] host_out_data,
	output logic host_out_last,
	input  logic host_out_ready
);
	arb_state_e state;
	byte_cnt_t byte_cnt;
	logic held;
	logic [7:0] eid_q;
	logic ok_q;
	reply_code_e code;

	assign code = ok_q ? REPLY_ACK : REPLY_NAK;
	// One reply slot, refilled once the held reply is fully sent
	assign reply.ready = !held;
	assign rx_in.ready = (state == ARB_RX) && host_out_ready;

	always_comb begin
		host_out_valid = 1'b0;
		host_out_data = rx_in.data;
		host_out_last = rx_in.last;
		case (state)
			ARB_RX: host_out_valid = rx_in.valid;
			ARB_REPLY: begin
				host_out_valid = 1'b1;
				host_out_last = (byte_cnt == 2'd2);
				case (byte_cnt)
					2'd0: host_out_data = reply_flag_byte;
					2'd1: host_out_data = eid_q;
					default: host_out_data = code;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reply.valid && reply.ready) begin
			eid_q <= reply.eid;
			ok_q <= reply.ok;
		end
	end

	// Source switches only between frames
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ARB_IDLE;
			byte_cnt <= '0;
			held <= 1'b0;
		end else begin
			if (reply.valid && reply.ready)
				held <= 1'b1;
			case (state)
				ARB_IDLE: begin
					byte_cnt <= '0;
					if (rx_in.valid)
						state <= ARB_RX;
					else if (held)
						state <= ARB_REPLY;
				end
				ARB_RX: begin
					if (rx_in.valid && rx_in.ready && rx_in.last)
						state <= ARB_IDLE;
				end
				ARB_REPLY: begin
					if (host_out_ready) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (byte_cnt == 2'd2) begin
							held <= 1'b0;
							state <= ARB_IDLE;
						end
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end
endmodule

/* design/mbus_bridge_top.sv */
`timescale 1ns/1ps

module mbus_bridge_top import mbus_reg_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic host_in_valid,
	output logic host_in_ready,
	input  logic [7:0] host_in_data,
	input  logic host_in_last,
	output logic host_out_valid,
	input  logic host_out_ready,
	output logic [7:0] host_out_data,
	output logic host_out_last,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [31:0] tx_addr,
	output logic [31:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input  logic tx_ack,
	input  logic tx_succ,
	input  logic tx_fail,
	output logic tx_resp_ack,
	input  logic [31:0] rx_addr,
	input  logic [31:0] rx_data,
	input  logic rx_req,
	output logic rx_ack,
	input  logic rx_pend,
	input  logic rx_fail,
	input  logic rx_broadcast,
	output logic master_en
);
	ctrl_t ctrl;
	logic [7:0] seq_tag;
	logic tx_done;
	logic tx_ok;
	logic rx_frame_start;

	byte_stream_if rx_bus ();
	reply_if reply_bus ();

	assign master_en = ctrl.master_en;

	mbus_cfg_regs regs0 (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.tx_done(tx_done),
		.tx_ok(tx_ok),
		.rx_frame_start(rx_frame_start),
		.ctrl(ctrl),
		.seq_tag(seq_tag)
	);

	mbus_tx_packer pack0 (
		.clk(clk),
		.reset(reset),
		.host_in_valid(host_in_valid),
		.host_in_data(host_in_data),
		.host_in_last(host_in_last),
		.host_in_ready(host_in_ready),
		.enable(ctrl.enable),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_pend(tx_pend),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack),
		.reply(reply_bus.source),
		.tx_done(tx_done),
		.tx_ok(tx_ok)
	);

	mbus_rx_unpacker unpack0 (
		.clk(clk),
		.reset(reset),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_req(rx_req),
		.rx_pend(rx_pend),
		.rx_fail(rx_fail),
		.rx_broadcast(rx_broadcast),
		.rx_ack(rx_ack),
		.seq_tag(seq_tag),
		.enable(ctrl.enable),
		.rx_out(rx_bus.source),
		.rx_frame_start(rx_frame_start)
	);

	host_reply_arbiter arb0 (
		.clk(clk),
		.reset(reset),
		.rx_in(rx_bus.sink),
		.reply(reply_bus.sink),
		.host_out_valid(host_out_valid),
		.host_out_data(host_out_data),
		.host_out_last(host_out_last),
		.host_out_ready(host_out_ready)
	);
endmodule

/* design/mbus_cfg_regs.sv */
`timescale 1ns/1ps

module mbus_cfg_regs import mbus_reg_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic tx_done,
	input  logic tx_ok,
	input  logic rx_frame_start,
	output ctrl_t ctrl,
	output logic [7:0] seq_tag
);
	logic [31:0] tx_ok_cnt;
	logic [31:0] tx_fail_cnt;
	logic [31:0] rx_frame_cnt;
	logic addr_hit;
	logic access;
	logic wr_en;

	// No wait states, every access ends in its access phase
	assign access = psel && penable;
	assign wr_en = access && pwrite && addr_hit;
	assign pready = 1'b1;
	assign pslverr = access && !addr_hit;

	always_comb begin
		addr_hit = 1'b1;
		prdata = '0;
		case (reg_addr_e'(paddr))
			REG_CTRL: prdata = {30'd0, ctrl};
			REG_SEQ: prdata = {24'd0, seq_tag};
			REG_TX_OK: prdata = tx_ok_cnt;
			REG_TX_FAIL: prdata = tx_fail_cnt;
			REG_RX_FRAMES: prdata = rx_frame_cnt;
			default: addr_hit = 1'b0;
		endcase
	end

	// A bus write wins over a counter event in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ctrl <= '0;
			seq_tag <= '0;
			tx_ok_cnt <= '0;
			tx_fail_cnt <= '0;
			rx_frame_cnt <= '0;
		end else begin
			if (wr_en && paddr == REG_CTRL)
				ctrl <= ctrl_t'(pwdata[1:0]);

			if (wr_en && paddr == REG_SEQ)
				seq_tag <= pwdata[7:0];
			else if (rx_frame_start)
				seq_tag <= seq_tag + 8'd1;

			if (wr_en && paddr == REG_TX_OK)
				tx_ok_cnt <= pwdata;
			else if (tx_done && tx_ok)
				tx_ok_cnt <= tx_ok_cnt + 32'd1;

			if (wr_en && paddr == REG_TX_FAIL)
				tx_fail_cnt <= pwdata;
			else if (tx_done && !tx_ok)
				tx_fail_cnt <= tx_fail_cnt + 32'd1;

			if (wr_en && paddr == REG_RX_FRAMES)
				rx_frame_cnt <= pwdata;
			else if (rx_frame_start)
				rx_frame_cnt <= rx_frame_cnt + 32'd1;
		end
	end
endmodule

/* design/mbus_frame_pkg.sv */
package mbus_frame_pkg;

	// Lead bytes of the two frame kinds on the host output
	localparam logic [7:0] rx_flag_byte = 8'h62;
	localparam logic [7:0] reply_flag_byte = 8'h61;

	// Bit positions in the RX status byte
	localparam int status_fail_bit = 2;
	localparam int status_bcast_bit = 1;

	typedef enum logic [7:0] {
		REPLY_NAK = 8'h00,
		REPLY_ACK = 8'h01
	} reply_code_e;

	typedef enum logic [2:0] {
		TX_EID, TX_ADDR, TX_DATA, TX_REQ, TX_ACK_LOW, TX_RESULT, TX_REPLY
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE, RX_FLAG, RX_TAG, RX_ADDR, RX_DATA, RX_ACK_LOW, RX_WAIT, RX_STATUS
	} rx_state_e;

	typedef enum logic [1:0] {
		ARB_IDLE, ARB_RX, ARB_REPLY
	} arb_state_e;

	// Byte position inside a 32-bit word, MSB first
	typedef logic [1:0] byte_cnt_t;

endpackage

/* design/mbus_reg_pkg.sv */
package mbus_reg_pkg;

	localparam int apb_addr_w = 8;

	typedef enum logic [apb_addr_w-1:0] {
		REG_CTRL      = 8'h00,
		REG_SEQ       = 8'h04,
		REG_TX_OK     = 8'h08,
		REG_TX_FAIL   = 8'h0C,
		REG_RX_FRAMES = 8'h10
	} reg_addr_e;

	// CTRL layout, enable in bit 0
	typedef struct packed {
		logic master_en;
		logic enable;
	} ctrl_t;

endpackage

/* design/mbus_rx_unpacker.sv */
`timescale 1ns/1ps

module mbus_rx_unpacker import mbus_frame_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] rx_addr,
	input  logic [31:0] rx_data,
	input  logic rx_req,
	input  logic rx_pend,
	input  logic rx_fail,
	input  logic rx_broadcast,
	output logic rx_ack,
	input  logic [7:0] seq_tag,
	input  logic enable,
	byte_stream_if.source rx_out,
	output logic rx_frame_start
);
	rx_state_e state;
	byte_cnt_t byte_cnt;
	logic [31:0] addr_q;
	logic [31:0] data_q;
	logic [7:0] tag_q;
	logic [7:0] status_q;
	logic pend_q;
	logic fail_only;
	logic can_take;
	logic capture;
	logic fail_ack;
	logic sent;

	// Words are taken only once the previous bytes are all out
	assign can_take = (state == RX_IDLE && enable) || state == RX_WAIT;
	assign capture = can_take && rx_req && !rx_ack;
	assign fail_ack = can_take && rx_fail && !rx_req && !rx_ack;
	assign rx_frame_start = (state == RX_IDLE) && (capture || fail_ack);
	assign sent = rx_out.valid && rx_out.ready;

	assign rx_out.valid = state inside {RX_FLAG, RX_TAG, RX_ADDR, RX_DATA, RX_STATUS};
	assign rx_out.last = (state == RX_STATUS);

	always_comb begin
		case (state)
			RX_FLAG: rx_out.data = rx_flag_byte;
			RX_TAG: rx_out.data = tag_q;
			RX_ADDR: rx_out.data = addr_q[{~byte_cnt, 3'b000} +: 8];
			RX_DATA: rx_out.data = data_q[{~byte_cnt, 3'b000} +: 8];
			default: rx_out.data = status_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			data_q <= rx_data;
			if (state == RX_IDLE)
				addr_q <= rx_addr;
		end
		// Tag is sampled before the register block advances it
		if (rx_frame_start)
			tag_q <= seq_tag;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			byte_cnt <= '0;
			rx_ack <= 1'b0;
			status_q <= '0;
			pend_q <= 1'b0;
			fail_only <= 1'b0;
		end else begin
			// Release ack once the layer drops the signal it was raised for
			if (rx_ack && !(fail_only ? rx_fail : rx_req))
				rx_ack <= 1'b0;
			if (capture || fail_ack) begin
				rx_ack <= 1'b1;
				pend_q <= capture && rx_pend;
				fail_only <= fail_ack;
			end
			if (sent && (state == RX_ADDR || state == RX_DATA))
				byte_cnt <= byte_cnt + 2'd1;

			case (state)
				RX_IDLE: begin
					byte_cnt <= '0;
					status_q <= '0;
					status_q[status_fail_bit] <= rx_fail;
					status_q[status_bcast_bit] <= rx_broadcast;
					if (capture || fail_ack)
						state <= RX_FLAG;
				end
				RX_FLAG: if (sent) state <= RX_TAG;
				RX_TAG: if (sent) state <= fail_only ? RX_ACK_LOW : RX_ADDR;
				RX_ADDR: if (sent && byte_cnt == 2'd3) state <= RX_DATA;
				RX_DATA: if (sent && byte_cnt == 2'd3) state <= RX_ACK_LOW;
				RX_ACK_LOW: begin
					if (!rx_ack)
						state <= pend_q ? RX_WAIT : RX_STATUS;
				end
				RX_WAIT: begin
					if (capture) begin
						status_q[status_fail_bit] <= status_q[status_fail_bit] | rx_fail;
						status_q[status_bcast_bit] <= status_q[status_bcast_bit] | rx_broadcast;
						state <= RX_DATA;
					end else if (fail_ack) begin
						// Message aborted between words
						status_q[status_fail_bit] <= 1'b1;
						state <= RX_ACK_LOW;
					end
				end
				RX_STATUS: if (sent) state <= RX_IDLE;
				default: state <= RX_IDLE;
			endcase
		end
	end
endmodule

/* design/mbus_tx_packer.sv */
`timescale 1ns/1ps

module mbus_tx_packer import mbus_frame_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic host_in_valid,
	input  logic [7:0] host_in_data,
	input  logic host_in_last,
	output logic host_in_ready,
	input  logic enable,
	output logic [31:0] tx_addr,
	output logic [31:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input  logic tx_ack,
	input  logic tx_succ,
	input  logic tx_fail,
	output logic tx_resp_ack,
	reply_if.source reply,
	output logic tx_done,
	output logic tx_ok
);
	tx_state_e state;
	byte_cnt_t byte_cnt;
	logic [7:0] eid;
	logic ok;
	logic take;

	// New frames only start while enabled
	assign host_in_ready = (state == TX_EID && enable) || state == TX_ADDR || state == TX_DATA;
	assign take = host_in_valid && host_in_ready;

	assign reply.valid = (state == TX_REPLY);
	assign reply.eid = eid;
	assign reply.ok = ok;
	assign tx_done = reply.valid && reply.ready;
	assign tx_ok = tx_done && ok;

	// First data byte of a word clears the rest, so a short word is zero padded
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				TX_EID: eid <= host_in_data;
				TX_ADDR: tx_addr <= {tx_addr[23:0], host_in_data};
				TX_DATA: begin
					if (byte_cnt == 2'd0)
						tx_data <= {host_in_data, 24'd0};
					else
						tx_data[{~byte_cnt, 3'b000} +: 8] <= host_in_data;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= TX_EID;
			byte_cnt <= '0;
			ok <= 1'b0;
			tx_pend <= 1'b0;
			tx_req <= 1'b0;
			tx_resp_ack <= 1'b0;
		end else begin
			case (state)
				TX_EID: begin
					byte_cnt <= '0;
					ok <= 1'b0;
					// A frame ending here has no data and is NAKed
					if (take)
						state <= host_in_last ? TX_REPLY : TX_ADDR;
				end
				TX_ADDR: begin
					if (take) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (host_in_last)
							state <= TX_REPLY;
						else if (byte_cnt == 2'd3)
							state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (take) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (host_in_last || byte_cnt == 2'd3) begin
							tx_pend <= !host_in_last;
							tx_req <= 1'b1;
							state <= TX_REQ;
						end
					end
				end
				TX_REQ: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						state <= TX_ACK_LOW;
					end
				end
				TX_ACK_LOW: begin
					if (!tx_ack)
						state <= tx_pend ? TX_DATA : TX_RESULT;
				end
				TX_RESULT: begin
					// Hold resp_ack until the layer drops its outcome
					if (!tx_resp_ack && (tx_succ || tx_fail)) begin
						tx_resp_ack <= 1'b1;
						ok <= tx_succ;
					end else if (tx_resp_ack && !tx_succ && !tx_fail) begin
						tx_resp_ack <= 1'b0;
						state <= TX_REPLY;
					end
				end
				TX_REPLY: begin
					if (reply.ready)
						state <= TX_EID;
				end
				default: state <= TX_EID;
			endcase
		end
	end
endmodule

/* design/reply_if.sv */
`timescale 1ns/1ps

interface reply_if;
	logic valid;
	logic ready;
	logic [7:0] eid;
	logic ok;

	modport source (output valid, output eid, output ok, input ready);
	modport sink (input valid, input eid, input ok, output ready);
endinterface

/* run_sim.sh */
#!/bin/bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module mbus_bridge_tb -o mbus_bridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mbus_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "No result line in sim.log"
	exit 1
fi
exit 0

/* sim/mbus_bridge_tb.sv */
`timescale 1ns/1ps

module mbus_bridge_tb import mbus_frame_pkg::*, mbus_reg_pkg::*; ();
	typedef logic [7:0] byte_q_t[$];

	// Roughly eight frames, each well under this many cycles with stalls
	localparam int n_frames = 8;
	localparam int frame_cycles = 400;
	localparam int cycle_limit = n_frames * frame_cycles + 100;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic host_in_valid, host_in_ready, host_in_last;
	logic [7:0] host_in_data;
	logic host_out_valid, host_out_last;
	logic host_out_ready = 1'b0;
	logic [7:0] host_out_data;
	logic psel, penable, pwrite, pready, pslverr;
	logic [7:0] paddr;
	logic [31:0] pwdata, prdata;
	logic [31:0] tx_addr, tx_data, rx_addr, rx_data;
	logic tx_pend, tx_req, tx_ack, tx_succ, tx_fail, tx_resp_ack;
	logic rx_req, rx_ack, rx_pend, rx_fail, rx_broadcast, master_en;

	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	logic [31:0] lfsr_state = 32'hf2ef;
	logic stall_en = 1'b0;
	logic tx_fail_mode = 1'b0;

	// Expected host output with last in bit 8
	logic [8:0] exp_rx[$];
	logic [8:0] exp_reply[$];
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic exp_pend[$];

	mbus_bridge_top dut0 (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, run did not finish", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] next_rand(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_code(input string name, input reply_code_e got, input reply_code_e exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
			value_errors++;
		end
	endtask

	// Expected layer words and reply for one host frame
	function automatic void build_tx_expect(input byte_q_t f, input logic fail);
		logic [31:0] addr;
		logic [31:0] word;
		int n_data;
		n_data = f.size() - 5;
		addr = {f[1], f[2], f[3], f[4]};
		for (int w = 0; n_data > 0 && w * 4 < n_data; w++) begin
			word = '0;
			for (int b = 0; b < 4; b++)
				if (w * 4 + b < n_data)
					word[31 - 8 * b -: 8] = f[5 + w * 4 + b];
			exp_addr.push_back(addr);
			exp_data.push_back(word);
			exp_pend.push_back((w + 1) * 4 < n_data);
		end
		exp_reply.push_back({1'b0, reply_flag_byte});
		exp_reply.push_back({1'b0, f[0]});
		if (n_data > 0 && !fail)
			exp_reply.push_back({1'b1, 8'(REPLY_ACK)});
		else
			exp_reply.push_back({1'b1, 8'(REPLY_NAK)});
	endfunction

	function automatic void build_rx_expect(input logic [7:0] tag, input logic [31:0] addr,
			input logic [31:0] w0, input logic [31:0] w1, input logic fail, input logic bcast);
		logic [31:0] words[3];
		words = '{addr, w0, w1};
		exp_rx.push_back({1'b0, rx_flag_byte});
		exp_rx.push_back({1'b0, tag});
		for (int w = 0; w < 3; w++)
			for (int b = 0; b < 4; b++)
				exp_rx.push_back({1'b0, words[w][31 - 8 * b -: 8]});
		exp_rx.push_back({1'b1, 5'd0, fail, bcast, 1'b0});
	endfunction

	// Host output compare that tells the frame kind by its first byte
	int kind = 0;
	int idx = 0;
	always @(posedge clk) begin
		logic [8:0] e;
		if (!reset && host_out_valid && host_out_ready) begin
			if (kind == 0) begin
				idx = 0;
				if (host_out_data == rx_flag_byte && exp_rx.size() > 0)
					kind = 1;
				else if (host_out_data == reply_flag_byte && exp_reply.size() > 0)
					kind = 2;
				else begin
					$display("Unexpected frame start byte %h at %0t", host_out_data, $time);
					other_errors++;
				end
			end
			if (kind != 0) begin
				e = (kind == 1) ? exp_rx.pop_front() : exp_reply.pop_front();
				if (kind == 2 && idx == 2)
					check_code("host_out_data", reply_code_e'(host_out_data), reply_code_e'(e[7:0]));
				else
					check_byte("host_out_data", host_out_data, e[7:0]);
				check_flag("host_out_last", host_out_last, e[8]);
				idx++;
				if (e[8])
					kind = 0;
			end
		end
	end

	always @(negedge clk) begin
		logic [31:0] r;
		r = 32'd1;
		if (stall_en)
			r = next_rand(1);
		host_out_ready = !reset && r[0];
	end

	// Layer TX model with a four-phase handshake per word and then the outcome
	initial begin
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		forever begin
			@(posedge clk);
			if (tx_req) begin
				if (exp_addr.size() == 0) begin
					$display("Layer saw a tx_req that no frame should produce at %0t", $time);
					other_errors++;
				end else begin
					check_word("tx_addr", tx_addr, exp_addr.pop_front());
					check_word("tx_data", tx_data, exp_data.pop_front());
					check_flag("tx_pend", tx_pend, exp_pend.pop_front());
				end
				@(negedge clk) tx_ack = 1'b1;
				do @(posedge clk); while (tx_req);
				@(negedge clk) tx_ack = 1'b0;
				if (!tx_pend) begin
					@(negedge clk);
					tx_succ = !tx_fail_mode;
					tx_fail = tx_fail_mode;
					do @(posedge clk); while (!tx_resp_ack);
					@(negedge clk);
					tx_succ = 1'b0;
					tx_fail = 1'b0;
					do @(posedge clk); while (tx_resp_ack);
				end
			end
		end
	end

	task automatic send_host(input byte_q_t f);
		for (int i = 0; i < f.size(); i++) begin
			@(negedge clk);
			host_in_valid = 1'b1;
			host_in_data = f[i];
			host_in_last = (i == f.size() - 1);
			do @(posedge clk); while (!host_in_ready);
		end
		@(negedge clk);
		host_in_valid = 1'b0;
		host_in_last = 1'b0;
	endtask

	task automatic send_rx(input logic [31:0] addr, input logic [31:0] w0, input logic [31:0] w1,
			input logic fail, input logic bcast);
		for (int i = 0; i < 2; i++) begin
			@(negedge clk);
			rx_addr = addr;
			rx_data = (i == 0) ? w0 : w1;
			rx_pend = (i == 0);
			rx_fail = fail && i == 1;
			rx_broadcast = bcast;
			rx_req = 1'b1;
			do @(posedge clk); while (!rx_ack);
			@(negedge clk);
			rx_req = 1'b0;
			rx_fail = 1'b0;
			rx_broadcast = 1'b0;
			do @(posedge clk); while (rx_ack);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk) penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk) penable = 1'b1;
		#4;
		data = prdata;
		err = pslverr;
		check_flag("pready", pready, 1'b1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] v;
		logic err;
		apb_read(addr, v, err);
		check_word(name, v, exp);
		check_flag({name, " pslverr"}, err, 1'b0);
	endtask

	task automatic wait_drained();
		while (exp_rx.size() || exp_reply.size() || exp_addr.size() || kind != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
	endtask

	task automatic random_frame(input logic [7:0] eid, input int n_data, output byte_q_t f);
		logic [31:0] r;
		f = '{eid, 8'h10, 8'h20, 8'h30, 8'h44};
		for (int i = 0; i < n_data; i++) begin
			r = next_rand(8);
			f.push_back(r[7:0]);
		end
	endtask

	initial begin
		byte_q_t f;
		logic [31:0] v;
		logic err;
		host_in_valid = 1'b0;
		host_in_data = '0;
		host_in_last = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rx_addr = '0;
		rx_data = '0;
		rx_req = 1'b0;
		rx_pend = 1'b0;
		rx_fail = 1'b0;
		rx_broadcast = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk) reset = 1'b0;

		// Handshake outputs idle and the bridge disabled out of reset
		check_flag("host_in_ready", host_in_ready, 1'b0);
		check_flag("host_out_valid", host_out_valid, 1'b0);
		check_flag("tx_req", tx_req, 1'b0);
		check_flag("tx_resp_ack", tx_resp_ack, 1'b0);
		check_flag("rx_ack", rx_ack, 1'b0);
		check_flag("pslverr", pslverr, 1'b0);
		check_flag("master_en", master_en, 1'b0);

		// Registers
		check_reg("CTRL", REG_CTRL, 0);
		check_reg("SEQ", REG_SEQ, 0);
		check_reg("TX_OK", REG_TX_OK, 0);
		check_reg("TX_FAIL", REG_TX_FAIL, 0);
		check_reg("RX_FRAMES", REG_RX_FRAMES, 0);
		apb_write(REG_CTRL, 32'h3);
		apb_write(REG_SEQ, 32'h5a);
		check_reg("CTRL", REG_CTRL, 32'h3);
		check_reg("SEQ", REG_SEQ, 32'h5a);
		check_flag("master_en", master_en, 1'b1);
		apb_read(8'h14, v, err);
		check_flag("pslverr", err, 1'b1);

		// TX success with 2.5 words, then failure and the empty frame
		random_frame(8'h11, 10, f);
		build_tx_expect(f, 1'b0);
		send_host(f);
		wait_drained();
		check_reg("TX_OK", REG_TX_OK, 1);
		tx_fail_mode = 1'b1;
		random_frame(8'h22, 4, f);
		build_tx_expect(f, 1'b1);
		send_host(f);
		wait_drained();
		tx_fail_mode = 1'b0;
		f = '{8'h33};
		build_tx_expect(f, 1'b0);
		send_host(f);
		wait_drained();
		check_reg("TX_FAIL", REG_TX_FAIL, 2);

		// RX message tagged with the current SEQ
		build_rx_expect(8'h5a, 32'hA0B0C0D0, 32'h01020304, 32'hF5E6D7C8, 1'b0, 1'b1);
		send_rx(32'hA0B0C0D0, 32'h01020304, 32'hF5E6D7C8, 1'b0, 1'b1);
		wait_drained();
		check_reg("SEQ", REG_SEQ, 32'h5b);
		check_reg("RX_FRAMES", REG_RX_FRAMES, 1);

		// RX and a TX reply close together under random stalls
		stall_en = 1'b1;
		random_frame(8'h44, 8, f);
		build_tx_expect(f, 1'b0);
		build_rx_expect(8'h5b, 32'h12345678, 32'hDEADBEEF, 32'h0BADF00D, 1'b1, 1'b0);
		fork
			send_host(f);
			send_rx(32'h12345678, 32'hDEADBEEF, 32'h0BADF00D, 1'b1, 1'b0);
		join
		wait_drained();
		stall_en = 1'b0;
		check_reg("TX_OK", REG_TX_OK, 2);
		check_reg("RX_FRAMES", REG_RX_FRAMES, 2);

		// Disabled bridge holds off both sides
		apb_write(REG_CTRL, 32'h0);
		build_rx_expect(8'h5c, 32'h55AA55AA, 32'h11112222, 32'h33334444, 1'b0, 1'b0);
		fork
			send_rx(32'h55AA55AA, 32'h11112222, 32'h33334444, 1'b0, 1'b0);
			begin
				repeat (20) begin
					@(posedge clk);
					check_flag("host_in_ready", host_in_ready, 1'b0);
					check_flag("rx_ack", rx_ack, 1'b0);
				end
				apb_write(REG_CTRL, 32'h1);
			end
		join
		wait_drained();
		check_reg("SEQ", REG_SEQ, 32'h5d);
		check_reg("RX_FRAMES", REG_RX_FRAMES, 3);

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end
endmodule

/* verilog.f */
design/mbus_frame_pkg.sv
design/mbus_reg_pkg.sv
design/byte_stream_if.sv
design/reply_if.sv
design/mbus_cfg_regs.sv
design/mbus_tx_packer.sv
design/mbus_rx_unpacker.sv
design/host_reply_arbiter.sv
design/mbus_bridge_top.sv
sim/mbus_bridge_tb.sv
